//--- design/radio_pkg.sv
// Shared register map, widths and stage structs for the radio control core
// Register index is the APB word address, paddr[9:2]
// Everything runs on the single bus clock

`default_nettype none

package radio_pkg;

   localparam int DATA_W = 32;           // APB data and sample width
   localparam int ADDR_W = 10;
   localparam int TIME_W = 64;

   ////////////////////////////////////////////////////////////
   // Write register indices
   ////////////////////////////////////////////////////////////
   localparam logic [7:0] SR_LOOPBACK    = 8'd6;
   localparam logic [7:0] SR_ATR_IDLE    = 8'd12;
   localparam logic [7:0] SR_ATR_TX      = 8'd13;
   localparam logic [7:0] SR_TEST        = 8'd21;
   localparam logic [7:0] SR_CODEC_IDLE  = 8'd22;
   localparam logic [7:0] SR_TIME_HI     = 8'd128;
   localparam logic [7:0] SR_TIME_LO     = 8'd129;
   localparam logic [7:0] SR_TIME_CTRL   = 8'd130;  // Write loads staged time
   localparam logic [7:0] SR_CMD         = 8'd160;  // Write arms the command
   localparam logic [7:0] SR_CMD_TIME_HI = 8'd161;
   localparam logic [7:0] SR_CMD_TIME_LO = 8'd162;
   localparam logic [7:0] SR_CW0         = 8'd164;
   localparam logic [7:0] SR_CW1         = 8'd165;
   localparam logic [7:0] SR_CW2         = 8'd166;

   // Read-only indices
   localparam logic [7:0] RB_TIME_LO = 8'd32;     // Also snapshots the high word
   localparam logic [7:0] RB_TIME_HI = 8'd33;
   localparam logic [7:0] RB_PPS_LO  = 8'd34;
   localparam logic [7:0] RB_PPS_HI  = 8'd35;
   localparam logic [7:0] RB_TX      = 8'd36;
   localparam logic [7:0] RB_RX      = 8'd37;
   localparam logic [7:0] RB_STATUS  = 8'd38;

   // Status word bits
   localparam int ST_RUN     = 0;
   localparam int ST_PENDING = 1;
   localparam int ST_LATE    = 2;

   localparam int CMD_RUN_BIT = 0;

   typedef struct packed {
      logic              stb;
      logic [TIME_W-1:0] value;
   } time_load_t;

   typedef struct packed {
      logic              stb;
      logic              run;
      logic [TIME_W-1:0] cmd_time;
   } cmd_arm_t;

   typedef struct packed {
      logic              loopback;
      logic [DATA_W-1:0] codec_idle;
      logic [DATA_W-1:0] atr_idle;
      logic [DATA_W-1:0] atr_tx;
      logic [DATA_W-1:0] cw0;
      logic [15:0]       cw1;
      logic [15:0]       cw2;
   } radio_cfg_t;

   // Field order puts run at bit 0
   typedef struct packed {
      logic late;
      logic pending;
      logic run;
   } radio_status_t;

endpackage

`default_nettype wire

//--- design/radio_apb_regs.sv
// APB slave with zero wait states, pslverr tied low
// Writes land at the access-phase edge; unmapped indices read 0
// Reading RB_TIME_LO latches the high word for a coherent 64-bit read

`timescale 1ns/1ns
`default_nettype none

module radio_apb_regs (
   input  wire                                i_clk,
   input  wire                                i_rst_n,
   input  wire                                i_psel,
   input  wire                                i_penable,
   input  wire                                i_pwrite,
   input  wire [radio_pkg::ADDR_W-1:0]        i_paddr,
   input  wire [radio_pkg::DATA_W-1:0]        i_pwdata,
   output logic [radio_pkg::DATA_W-1:0]       o_prdata,
   output logic                               o_pready,
   output logic                               o_pslverr,
   input  wire [radio_pkg::TIME_W-1:0]        i_time,
   input  wire [radio_pkg::TIME_W-1:0]        i_pps_time,
   input  radio_pkg::radio_status_t           i_status,
   input  wire [radio_pkg::DATA_W-1:0]        i_tx_cap,
   input  wire [radio_pkg::DATA_W-1:0]        i_rx_cap,
   output radio_pkg::radio_cfg_t              o_cfg,
   output radio_pkg::time_load_t              o_time_load,
   output radio_pkg::cmd_arm_t                o_cmd_arm
);

   logic [7:0]                  reg_idx;
   logic                        wr_en;
   logic                        rd_en;
   radio_pkg::radio_cfg_t       cfg;
   logic [radio_pkg::DATA_W-1:0] test_reg;
   logic [radio_pkg::TIME_W-1:0] time_stage;   // Staged load value
   logic [radio_pkg::TIME_W-1:0] cmd_time;     // Staged command time
   logic                        cmd_run;
   logic                        load_stb;
   logic                        arm_stb;
   logic [radio_pkg::DATA_W-1:0] time_hi_snap;
   logic [radio_pkg::DATA_W-1:0] rd_data;

   assign reg_idx = i_paddr[radio_pkg::ADDR_W-1:2];
   assign wr_en   = i_psel & i_penable & i_pwrite;
   assign rd_en   = i_psel & i_penable & ~i_pwrite;

   ////////////////////////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////////////////////////
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cfg        <= '0;
         test_reg   <= '0;
         time_stage <= '0;
         cmd_time   <= '0;
         cmd_run    <= 1'b0;
         load_stb   <= 1'b0;
         arm_stb    <= 1'b0;
      end else begin
         load_stb <= wr_en && (reg_idx == radio_pkg::SR_TIME_CTRL);
         arm_stb  <= wr_en && (reg_idx == radio_pkg::SR_CMD);
         if (wr_en) begin
            case (reg_idx)
               radio_pkg::SR_LOOPBACK:    cfg.loopback   <= i_pwdata[0];
               radio_pkg::SR_ATR_IDLE:    cfg.atr_idle   <= i_pwdata;
               radio_pkg::SR_ATR_TX:      cfg.atr_tx     <= i_pwdata;
               radio_pkg::SR_TEST:        test_reg       <= i_pwdata;
               radio_pkg::SR_CODEC_IDLE:  cfg.codec_idle <= i_pwdata;
               radio_pkg::SR_TIME_HI:     time_stage[63:32] <= i_pwdata;
               radio_pkg::SR_TIME_LO:     time_stage[31:0]  <= i_pwdata;
               radio_pkg::SR_CMD:         cmd_run <= i_pwdata[radio_pkg::CMD_RUN_BIT];
               radio_pkg::SR_CMD_TIME_HI: cmd_time[63:32] <= i_pwdata;
               radio_pkg::SR_CMD_TIME_LO: cmd_time[31:0]  <= i_pwdata;
               radio_pkg::SR_CW0:         cfg.cw0 <= i_pwdata;
               radio_pkg::SR_CW1:         cfg.cw1 <= i_pwdata[15:0];
               radio_pkg::SR_CW2:         cfg.cw2 <= i_pwdata[15:0];
               default: ;                 // Unmapped, ignored
            endcase
         end
      end
   end

   // High word held from the last low-word read
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         time_hi_snap <= '0;
      end else if (rd_en && (reg_idx == radio_pkg::RB_TIME_LO)) begin
         time_hi_snap <= i_time[63:32];
      end
   end

   ////////////////////////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////////////////////////
   always_comb begin
      rd_data = '0;
      case (reg_idx)
         radio_pkg::SR_LOOPBACK:    rd_data[0] = cfg.loopback;
         radio_pkg::SR_ATR_IDLE:    rd_data = cfg.atr_idle;
         radio_pkg::SR_ATR_TX:      rd_data = cfg.atr_tx;
         radio_pkg::SR_TEST:        rd_data = test_reg;
         radio_pkg::SR_CODEC_IDLE:  rd_data = cfg.codec_idle;
         radio_pkg::SR_CMD_TIME_HI: rd_data = cmd_time[63:32];
         radio_pkg::SR_CMD_TIME_LO: rd_data = cmd_time[31:0];
         radio_pkg::SR_CW0:         rd_data = cfg.cw0;
         radio_pkg::SR_CW1:         rd_data[15:0] = cfg.cw1;
         radio_pkg::SR_CW2:         rd_data[15:0] = cfg.cw2;
         radio_pkg::RB_TIME_LO:     rd_data = i_time[31:0];
         radio_pkg::RB_TIME_HI:     rd_data = time_hi_snap;
         radio_pkg::RB_PPS_LO:      rd_data = i_pps_time[31:0];
         radio_pkg::RB_PPS_HI:      rd_data = i_pps_time[63:32];
         radio_pkg::RB_TX:          rd_data = i_tx_cap;
         radio_pkg::RB_RX:          rd_data = i_rx_cap;
         radio_pkg::RB_STATUS: begin
            rd_data[radio_pkg::ST_RUN]     = i_status.run;
            rd_data[radio_pkg::ST_PENDING] = i_status.pending;
            rd_data[radio_pkg::ST_LATE]    = i_status.late;
         end
         default: rd_data = '0;
      endcase
   end

   assign o_prdata  = rd_data;
   assign o_pready  = 1'b1;
   assign o_pslverr = 1'b0;

   assign o_cfg       = cfg;
   assign o_time_load = '{stb: load_stb, value: time_stage};
   assign o_cmd_arm   = '{stb: arm_stb, run: cmd_run, cmd_time: cmd_time};

endmodule

`default_nettype wire

//--- design/radio_timekeeper.sv
// Free-running 64-bit time, loadable from software
// i_pps is assumed already synchronous to the bus clock

`timescale 1ns/1ns
`default_nettype none

module radio_timekeeper (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  radio_pkg::time_load_t         i_load,
   input  wire                           i_pps,
   output logic [radio_pkg::TIME_W-1:0]  o_time,
   output logic [radio_pkg::TIME_W-1:0]  o_pps_time
);

   logic pps_q;
   logic pps_qq;
   logic pps_rise;

   assign pps_rise = pps_q & ~pps_qq;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_time <= '0;
      end else if (i_load.stb) begin
         o_time <= i_load.value;
      end else begin
         o_time <= o_time + 1'b1;
      end
   end

   // Edge detect on the registered pulse
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pps_q      <= 1'b0;
         pps_qq     <= 1'b0;
         o_pps_time <= '0;
      end else begin
         pps_q  <= i_pps;
         pps_qq <= pps_q;
         if (pps_rise) o_pps_time <= o_time;
      end
   end

endmodule

`default_nettype wire

//--- design/radio_cmd_sched.sv
// Single-entry timed run/stop scheduler
// A new arm replaces a pending command; late is decided at arm time

`timescale 1ns/1ns
`default_nettype none

module radio_cmd_sched (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  radio_pkg::cmd_arm_t           i_arm,
   input  wire [radio_pkg::TIME_W-1:0]   i_time,
   output logic                          o_run,
   output radio_pkg::radio_status_t      o_status
);

   logic [radio_pkg::TIME_W-1:0] cmd_time;
   logic                         cmd_run;
   logic                         pending;
   logic                         was_late;   // Time had passed when armed
   logic                         late;
   logic                         due;

   assign due = pending && (i_time >= cmd_time);

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cmd_time <= '0;
         cmd_run  <= 1'b0;
         pending  <= 1'b0;
         was_late <= 1'b0;
         late     <= 1'b0;
         o_run    <= 1'b0;
      end else if (i_arm.stb) begin
         cmd_time <= i_arm.cmd_time;
         cmd_run  <= i_arm.run;
         pending  <= 1'b1;
         was_late <= (i_time >= i_arm.cmd_time);
      end else if (due) begin
         o_run   <= cmd_run;
         pending <= 1'b0;
         late    <= was_late;    // Cleared by an on-time command
      end
   end

   assign o_status = '{late: late, pending: pending, run: o_run};

endmodule

`default_nettype wire

//--- design/radio_tx_source.sv
// Codeword sequencer, alternates cw0 and {cw1, cw2} while running
// Sequence restarts at cw0 whenever run drops

`timescale 1ns/1ns
`default_nettype none

module radio_tx_source (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  wire                           i_run,
   input  radio_pkg::radio_cfg_t         i_cfg,
   output logic [radio_pkg::DATA_W-1:0]  o_sample
);

   logic hold_cw12;   // o_sample currently holds {cw1, cw2}

   // Idle keeps cw0 ready so the first running word is cw0
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         hold_cw12 <= 1'b0;
         o_sample  <= '0;
      end else if (i_run) begin
         hold_cw12 <= ~hold_cw12;
         o_sample  <= hold_cw12 ? i_cfg.cw0 : {i_cfg.cw1, i_cfg.cw2};
      end else begin
         hold_cw12 <= 1'b0;
         o_sample  <= i_cfg.cw0;
      end
   end

endmodule

`default_nettype wire

//--- design/radio_frontend.sv
// Transmit output register and ATR pin drive
// Loopback feeds the registered tx word into the rx capture

`timescale 1ns/1ns
`default_nettype none

module radio_frontend (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  wire                           i_run,
   input  wire [radio_pkg::DATA_W-1:0]   i_sample,
   input  radio_pkg::radio_cfg_t         i_cfg,
   input  wire [radio_pkg::DATA_W-1:0]   i_rx,
   output logic [radio_pkg::DATA_W-1:0]  o_tx,
   output logic [radio_pkg::DATA_W-1:0]  o_fe_gpio,
   output logic [radio_pkg::DATA_W-1:0]  o_tx_cap,
   output logic [radio_pkg::DATA_W-1:0]  o_rx_cap
);

   logic [radio_pkg::DATA_W-1:0] tx_q;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         tx_q      <= '0;
         o_fe_gpio <= '0;
      end else begin
         tx_q      <= i_run ? i_sample : i_cfg.codec_idle;
         o_fe_gpio <= i_run ? i_cfg.atr_tx : i_cfg.atr_idle;
      end
   end

   // Rx word as seen by software
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_rx_cap <= '0;
      end else begin
         o_rx_cap <= i_cfg.loopback ? tx_q : i_rx;
      end
   end

   assign o_tx     = tx_q;
   assign o_tx_cap = tx_q;

endmodule

`default_nettype wire

//--- design/radio_core.sv
// Radio control core, one clock domain, no back-pressure
// Path from an SR_CMD write to o_tx depends on the command time

`timescale 1ns/1ns
`default_nettype none

module radio_core (
   input  wire                           i_clk,
   input  wire                           i_rst_n,
   input  wire                           i_psel,
   input  wire                           i_penable,
   input  wire                           i_pwrite,
   input  wire [radio_pkg::ADDR_W-1:0]   i_paddr,
   input  wire [radio_pkg::DATA_W-1:0]   i_pwdata,
   output logic [radio_pkg::DATA_W-1:0]  o_prdata,
   output logic                          o_pready,
   output logic                          o_pslverr,
   input  wire [radio_pkg::DATA_W-1:0]   i_rx,
   input  wire                           i_pps,
   output logic [radio_pkg::DATA_W-1:0]  o_tx,
   output logic [radio_pkg::DATA_W-1:0]  o_fe_gpio
);

   radio_pkg::radio_cfg_t        cfg;
   radio_pkg::time_load_t        time_load;
   radio_pkg::cmd_arm_t          cmd_arm;
   radio_pkg::radio_status_t     status;
   logic [radio_pkg::TIME_W-1:0] cur_time;
   logic [radio_pkg::TIME_W-1:0] pps_time;
   logic                         run;
   logic [radio_pkg::DATA_W-1:0] sample;
   logic [radio_pkg::DATA_W-1:0] tx_cap;
   logic [radio_pkg::DATA_W-1:0] rx_cap;

   ////////////////////////////////////////////////////////////
   // Control plane
   ////////////////////////////////////////////////////////////
   radio_apb_regs radio_apb_regs_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
      .i_paddr(i_paddr), .i_pwdata(i_pwdata),
      .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
      .i_time(cur_time), .i_pps_time(pps_time), .i_status(status),
      .i_tx_cap(tx_cap), .i_rx_cap(rx_cap),
      .o_cfg(cfg), .o_time_load(time_load), .o_cmd_arm(cmd_arm)
   );

   radio_timekeeper radio_timekeeper_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_load(time_load), .i_pps(i_pps),
      .o_time(cur_time), .o_pps_time(pps_time)
   );

   radio_cmd_sched radio_cmd_sched_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_arm(cmd_arm), .i_time(cur_time),
      .o_run(run), .o_status(status)
   );

   ////////////////////////////////////////////////////////////
   // Transmit path
   ////////////////////////////////////////////////////////////
   radio_tx_source radio_tx_source_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_run(run), .i_cfg(cfg), .o_sample(sample)
   );

   radio_frontend radio_frontend_i (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_run(run), .i_sample(sample), .i_cfg(cfg), .i_rx(i_rx),
      .o_tx(o_tx), .o_fe_gpio(o_fe_gpio),
      .o_tx_cap(tx_cap), .o_rx_cap(rx_cap)
   );

endmodule

`default_nettype wire

//--- test/radio_core_tb_tasks.svh
// Helpers of the radio core testbench, included inside its module
// APB accesses assume zero wait states
// Each access spans three rising clock edges

`ifndef RADIO_CORE_TB_TASKS_SVH
`define RADIO_CORE_TB_TASKS_SVH

// 32-bit LCG step
function automatic logic [31:0] next_rand();
   rng_state = rng_state * 32'd1664525 + 32'd1013904223;
   return rng_state;
endfunction

task automatic check_word(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
   checks++;
   assert (got === exp) else begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
   end
endtask

task automatic check_window(input string name, input logic [63:0] got,
                            input logic [63:0] lo, input logic [63:0] hi);
   checks++;
   assert (got >= lo && got <= hi) else begin
      $display("FAILED t=%0t %s got %h expected %h to %h", $time, name, got, lo, hi);
      errors++;
   end
endtask

task automatic report_test(input string name, input int mark);
   tests++;
   if (errors == mark) begin
      $display("test %0d %s: ok", tests, name);
   end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - mark);
   end
endtask

////////////////////////////////////////////////////////////
// APB master side
////////////////////////////////////////////////////////////
task automatic apb_write(input logic [7:0] idx, input logic [31:0] data);
   @(posedge bus_clk);
   #1;
   psel   = 1'b1;
   pwrite = 1'b1;
   paddr  = {idx, 2'b00};
   pwdata = data;
   @(posedge bus_clk);
   #1;
   penable = 1'b1;
   @(posedge bus_clk);          // Write lands on this edge
   #1;
   psel    = 1'b0;
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [7:0] idx, output logic [31:0] data);
   @(posedge bus_clk);
   #1;
   psel   = 1'b1;
   pwrite = 1'b0;
   paddr  = {idx, 2'b00};
   @(posedge bus_clk);
   #1;
   penable = 1'b1;
   @(negedge bus_clk);          // Mid access phase
   data = prdata;
   check_word("o_pready", 32'(pready), 32'd1);
   check_word("o_pslverr", 32'(pslverr), 32'd0);
   @(posedge bus_clk);
   #1;
   psel    = 1'b0;
   penable = 1'b0;
endtask

// Low word first, the high word then comes from the snapshot
task automatic read_time(output logic [63:0] t);
   logic [31:0] lo;
   logic [31:0] hi;
   apb_read(radio_pkg::RB_TIME_LO, lo);
   apb_read(radio_pkg::RB_TIME_HI, hi);
   t = {hi, lo};
endtask

task automatic arm_cmd(input logic [63:0] cmd_at, input logic run);
   apb_write(radio_pkg::SR_CMD_TIME_HI, cmd_at[63:32]);
   apb_write(radio_pkg::SR_CMD_TIME_LO, cmd_at[31:0]);
   apb_write(radio_pkg::SR_CMD, {31'd0, run});
endtask

task automatic poll_status(input int bit_idx, input logic value, output logic [31:0] st);
   apb_read(radio_pkg::RB_STATUS, st);
   while (st[bit_idx] !== value) begin
      apb_read(radio_pkg::RB_STATUS, st);
   end
endtask

// Lets the source and frontend registers follow a change
task automatic settle_cycles();
   repeat (3) @(posedge bus_clk);
   @(negedge bus_clk);
endtask

`endif

//--- test/radio_core_tb.sv
// Testbench for the radio control core
// Settings are random words from an LCG with a fixed seed
// Expected values come from the register map and the stage timing rules

`timescale 1ns/1ns
`default_nettype none

module radio_core_tb;

   // Rough cycle budget of each test
   localparam int TEST_CYCLES = 150 + 30 + 60 + 250 + 40 + 50;
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;   // Timeout

   bit                           bus_clk;
   logic                         rst_n;
   logic                         psel;
   logic                         penable;
   logic                         pwrite;
   logic [radio_pkg::ADDR_W-1:0] paddr;
   logic [31:0]                  pwdata;
   logic [31:0]                  prdata;
   logic                         pready;
   logic                         pslverr;
   logic [31:0]                  rx;
   logic                         pps;
   logic [31:0]                  tx;
   logic [31:0]                  fe_gpio;
   logic [31:0]                  rng_state;
   int                           cycle_cnt;
   int                           checks;
   int                           errors;
   int                           tests;

   // Model of the settings written so far
   logic [31:0] m_codec_idle;
   logic [31:0] m_atr_idle;
   logic [31:0] m_atr_tx;
   logic [31:0] m_cw0;
   logic [31:0] m_cw12;

   `include "radio_core_tb_tasks.svh"

   radio_core radio_core_i (
      .i_clk(bus_clk), .i_rst_n(rst_n),
      .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
      .i_paddr(paddr), .i_pwdata(pwdata),
      .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
      .i_rx(rx), .i_pps(pps), .o_tx(tx), .o_fe_gpio(fe_gpio)
   );

   always #4 bus_clk = ~bus_clk;

   always @(posedge bus_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("Timeout: tests still running after %0d cycles", cycle_cnt);
         $display(">>> FAIL");
         $finish;
      end
   end

   initial begin
      logic [31:0] val;
      logic [31:0] rd;
      logic [31:0] st;
      logic [31:0] exp_tx;
      logic [63:0] t_load;
      logic [63:0] t_a;
      logic [63:0] t_b;
      logic [63:0] t_now;
      logic [63:0] cmd_t;
      int          mark;
      int          c0;

      rst_n     = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      rx        = '0;
      pps       = 1'b0;
      rng_state = 32'h4b53;
      repeat (8) @(posedge bus_clk);
      #1;
      rst_n = 1'b1;

      ////////////////////////////////////////////////////////////
      // Reset values and register access
      ////////////////////////////////////////////////////////////
      mark = errors;
      @(negedge bus_clk);
      check_word("o_tx", tx, '0);
      check_word("o_fe_gpio", fe_gpio, '0);
      apb_read(radio_pkg::RB_STATUS, st);
      check_word("status", st, '0);
      for (int i = 0; i < 20; i++) begin
         val = next_rand();
         apb_write(radio_pkg::SR_TEST, val);
         apb_read(radio_pkg::SR_TEST, rd);
         check_word("SR_TEST readback", rd, val);
      end
      report_test("reset and registers", mark);

      // Idle drive with no command armed
      mark = errors;
      m_codec_idle = next_rand();
      m_atr_idle   = next_rand();
      m_atr_tx     = next_rand();
      apb_write(radio_pkg::SR_CODEC_IDLE, m_codec_idle);
      apb_write(radio_pkg::SR_ATR_IDLE, m_atr_idle);
      apb_write(radio_pkg::SR_ATR_TX, m_atr_tx);
      settle_cycles();
      check_word("o_tx", tx, m_codec_idle);
      check_word("o_fe_gpio", fe_gpio, m_atr_idle);
      apb_read(radio_pkg::RB_TX, rd);
      check_word("RB_TX", rd, m_codec_idle);
      report_test("idle drive", mark);

      // Time load and a pps latch between two reads
      mark = errors;
      t_load = {next_rand(), next_rand()};
      t_load[63] = 1'b0;             // Keeps the window clear of a wrap
      apb_write(radio_pkg::SR_TIME_HI, t_load[63:32]);
      apb_write(radio_pkg::SR_TIME_LO, t_load[31:0]);
      apb_write(radio_pkg::SR_TIME_CTRL, 32'd1);
      c0 = cycle_cnt;
      read_time(t_a);
      check_window("loaded time", t_a, t_load, t_load + 64'(cycle_cnt - c0));
      read_time(t_a);
      @(posedge bus_clk);
      #1;
      pps = 1'b1;
      @(posedge bus_clk);
      #1;
      pps = 1'b0;
      settle_cycles();
      read_time(t_b);
      apb_read(radio_pkg::RB_PPS_LO, rd);
      apb_read(radio_pkg::RB_PPS_HI, val);
      check_window("pps time", {val, rd}, t_a, t_b);
      report_test("time load and pps", mark);

      ////////////////////////////////////////////////////////////
      // Timed start, codeword run, timed stop
      ////////////////////////////////////////////////////////////
      mark = errors;
      m_cw0  = next_rand();
      m_cw12 = next_rand();
      apb_write(radio_pkg::SR_CW0, m_cw0);
      apb_write(radio_pkg::SR_CW1, {16'd0, m_cw12[31:16]});
      apb_write(radio_pkg::SR_CW2, {16'd0, m_cw12[15:0]});
      read_time(t_a);
      cmd_t = t_a + 64'(20 + next_rand() % 41);
      arm_cmd(cmd_t, 1'b1);
      poll_status(radio_pkg::ST_RUN, 1'b1, st);
      check_word("status late", 32'(st[radio_pkg::ST_LATE]), '0);
      read_time(t_b);
      c0 = cycle_cnt;   // Four edges after the sample of t_b
      check_window("run start time", t_b, cmd_t, cmd_t + 64'd20);
      settle_cycles();
      for (int i = 0; i < 16; i++) begin
         t_now = t_b + 64'd4 + 64'(cycle_cnt - c0);
         // Run edge at cmd_t, then source and frontend add one edge each
         exp_tx = ((t_now - cmd_t) % 64'd2 == 64'd0) ? m_cw0 : m_cw12;
         check_word("o_tx", tx, exp_tx);
         check_word("o_fe_gpio", fe_gpio, m_atr_tx);
         @(negedge bus_clk);
      end
      read_time(t_a);
      arm_cmd(t_a + 64'd20, 1'b0);
      poll_status(radio_pkg::ST_RUN, 1'b0, st);
      settle_cycles();
      check_word("o_tx", tx, m_codec_idle);
      check_word("o_fe_gpio", fe_gpio, m_atr_idle);
      report_test("timed start and stop", mark);

      // Command time already in the past
      mark = errors;
      read_time(t_a);
      arm_cmd(t_a - 64'd10, 1'b1);
      poll_status(radio_pkg::ST_RUN, 1'b1, st);
      check_word("status pending", 32'(st[radio_pkg::ST_PENDING]), '0);
      check_word("status late", 32'(st[radio_pkg::ST_LATE]), 32'd1);
      report_test("late command", mark);

      // Rx capture from the pins and from the tx loopback
      mark = errors;
      rx = next_rand();
      settle_cycles();
      apb_read(radio_pkg::RB_RX, rd);
      check_word("RB_RX", rd, rx);
      apb_write(radio_pkg::SR_CMD, 32'd0);   // Staged time already past so run stops at once
      poll_status(radio_pkg::ST_RUN, 1'b0, st);
      apb_write(radio_pkg::SR_LOOPBACK, 32'd1);
      settle_cycles();
      apb_read(radio_pkg::RB_RX, rd);
      check_word("RB_RX", rd, m_codec_idle);
      report_test("loopback", mark);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- radio_core.f
+incdir+test
design/radio_pkg.sv
design/radio_apb_regs.sv
design/radio_timekeeper.sv
design/radio_cmd_sched.sv
design/radio_tx_source.sv
design/radio_frontend.sv
design/radio_core.sv
test/radio_core_tb.sv

//--- Makefile
# Verilator build and run of the radio core testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := radio_core_tb
FILELIST := radio_core.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@! grep -q ">>> FAIL" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
